// File: Bender.yml
package:
  name: mem_subsys

sources:
  - files:
      - verilog/mem_pkg.sv
      - verilog/lfsr.sv
      - verilog/sram_slave.sv
      - verilog/rd_arbiter.sv
      - verilog/mem_subsys_top.sv
  - target: simulation
    files:
      - sim/mem_subsys_sva.sv
      - sim/tb_mem_subsys.sv

// File: sim.f
verilog/mem_pkg.sv
verilog/lfsr.sv
verilog/sram_slave.sv
verilog/rd_arbiter.sv
verilog/mem_subsys_top.sv
sim/mem_subsys_sva.sv
sim/tb_mem_subsys.sv

// File: sim/mem_subsys_sva.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_sva
  import mem_pkg::*;
(
  input logic clk,
  input logic rst,
  input logic arvalid,
  input logic arready,
  input r_t   r,
  input logic rvalid,
  input logic rready,
  input logic awvalid,
  input logic awready,
  input logic wvalid,
  input logic wready,
  input b_t   b,
  input logic bvalid,
  input logic bready
);

  int   fails = 0;
  logic rd_open;
  logic wr_open;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_open <= 1'b0;
      wr_open <= 1'b0;
    end else begin
      // Read accepted but not yet answered.
      if (arvalid && arready) begin
        rd_open <= 1'b1;
      end else if (rvalid && rready) begin
        rd_open <= 1'b0;
      end
      // Write address taken and data still due.
      if (awvalid && awready) begin
        wr_open <= 1'b1;
      end else if (wvalid && wready) begin
        wr_open <= 1'b0;
      end
    end
  end

  rvalid_held: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid)
    else begin
      $error("rvalid dropped before the r transfer");
      fails++;
    end

  bvalid_held: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid)
    else begin
      $error("bvalid dropped before the b transfer");
      fails++;
    end

  r_stable: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> $stable(r))
    else begin
      $error("r changed while stalled");
      fails++;
    end

  b_stable: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> $stable(b))
    else begin
      $error("b changed while stalled");
      fails++;
    end

  // One read in flight at a time.
  ar_blocked: assert property (@(posedge clk) disable iff (rst)
    rd_open |-> !arready)
    else begin
      $error("arready high with a read outstanding");
      fails++;
    end

  wready_state: assert property (@(posedge clk) disable iff (rst)
    wready |-> wr_open)
    else begin
      $error("wready high outside WR_DATA");
      fails++;
    end

endmodule

bind sram_slave mem_subsys_sva i_sva (
  .clk     (clk),
  .rst     (rst),
  .arvalid (arvalid),
  .arready (arready),
  .r       (r),
  .rvalid  (rvalid),
  .rready  (rready),
  .awvalid (awvalid),
  .awready (awready),
  .wvalid  (wvalid),
  .wready  (wready),
  .b       (b),
  .bvalid  (bvalid),
  .bready  (bready)
);

`default_nettype wire

// File: sim/tb_mem_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsys
  import mem_pkg::*;
();

  localparam int TIMEOUT = 100;

  logic clk;
  logic rst;
  ar_t  if_ar;
  logic if_arvalid;
  logic if_arready;
  r_t   if_r;
  logic if_rvalid;
  logic if_rready;
  ar_t  ls_ar;
  logic ls_arvalid;
  logic ls_arready;
  r_t   ls_r;
  logic ls_rvalid;
  logic ls_rready;
  aw_t  ls_aw;
  logic ls_awvalid;
  logic ls_awready;
  w_t   ls_w;
  logic ls_wvalid;
  logic ls_wready;
  b_t   ls_b;
  logic ls_bvalid;
  logic ls_bready;

  data_t shadow [MEM_WORDS];
  addr_t used [$];
  int    checks;
  int    errors;
  int    if_resp_cnt;
  int    ls_resp_cnt;
  bit    if_rv_q;
  bit    ls_rv_q;
  bit    stall_en;

  mem_subsys_top i_dut (.*);

  always #4 clk = ~clk;

  // A response starts where rvalid rises at a port.
  always @(negedge clk) begin
    if (if_rvalid && !if_rv_q) begin
      if_resp_cnt++;
    end
    if (ls_rvalid && !ls_rv_q) begin
      ls_resp_cnt++;
    end
    if_rv_q = if_rvalid;
    ls_rv_q = ls_rvalid;
  end

  function automatic bit in_mem(addr_t a);
    return a < MEM_WORDS * 4;
  endfunction

  function automatic addr_t rand_addr();
    return $urandom_range(0, MEM_WORDS - 1) * 4;
  endfunction

  function automatic r_t expect_read(addr_t a);
    r_t e;
    e.data = in_mem(a) ? shadow[a / 4] : '0;
    e.resp = in_mem(a) ? RESP_OK : RESP_ERR;
    return e;
  endfunction

  task automatic check_value(input string sig, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("error %0t %s got %0h expected %0h", $time, sig, got, exp);
      errors++;
    end
  endtask

  task automatic check_done(input bit done, input string what);
    checks++;
    assert (done) else begin
      $display("timeout at %0t: the %s never completed", $time, what);
      errors++;
    end
  endtask

  function automatic bit stall_ready();
    return !stall_en || ($urandom % 3 != 0);
  endfunction

  task automatic ls_write(input addr_t addr, input data_t data, input strb_t strb);
    bit done;
    int n;
    ls_aw.addr = addr;
    ls_awvalid = 1'b1;
    done = 1'b0;
    for (n = 0; n < TIMEOUT && !done; n++) begin
      @(negedge clk);
      done = ls_awready;
    end
    check_done(done, "ls write address handshake");
    @(posedge clk);
    #1;
    ls_awvalid = 1'b0;
    ls_w.data  = data;
    ls_w.strb  = strb;
    ls_wvalid  = 1'b1;
    done = 1'b0;
    for (n = 0; n < TIMEOUT && !done; n++) begin
      @(negedge clk);
      done = ls_wready;
    end
    check_done(done, "ls write data handshake");
    @(posedge clk);
    #1;
    ls_wvalid = 1'b0;
    done = 1'b0;
    for (n = 0; n < TIMEOUT && !done; n++) begin
      ls_bready = stall_ready();
      @(negedge clk);
      done = ls_bvalid && ls_bready;
      if (!done) begin
        @(posedge clk);
        #1;
      end
    end
    check_done(done, "ls write response handshake");
    check_value("ls_b.resp", ls_b.resp, in_mem(addr) ? RESP_OK : RESP_ERR);
    @(posedge clk);
    #1;
    ls_bready = 1'b0;
    if (in_mem(addr)) begin
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
          shadow[addr / 4][8*i +: 8] = data[8*i +: 8];
        end
      end
    end
  endtask

  task automatic read_port(input bit use_ls, input addr_t addr);
    r_t    exp;
    r_t    got;
    r_t    first;
    bit    done;
    bit    seen;
    bit    rv;
    bit    rdy;
    int    n;
    string pfx;
    exp = expect_read(addr);
    pfx = use_ls ? "ls" : "if";
    if (use_ls) begin
      ls_ar.addr = addr;
      ls_arvalid = 1'b1;
    end else begin
      if_ar.addr = addr;
      if_arvalid = 1'b1;
    end
    done = 1'b0;
    for (n = 0; n < TIMEOUT && !done; n++) begin
      @(negedge clk);
      done = use_ls ? ls_arready : if_arready;
    end
    check_done(done, {pfx, " read address handshake"});
    @(posedge clk);
    #1;
    if (use_ls) begin
      ls_arvalid = 1'b0;
    end else begin
      if_arvalid = 1'b0;
    end
    done = 1'b0;
    seen = 1'b0;
    for (n = 0; n < TIMEOUT && !done; n++) begin
      rdy = stall_ready();
      if (use_ls) begin
        ls_rready = rdy;
      end else begin
        if_rready = rdy;
      end
      @(negedge clk);
      rv  = use_ls ? ls_rvalid : if_rvalid;
      got = use_ls ? ls_r : if_r;
      // A stalled response has to stay up and unchanged.
      if (seen) begin
        check_value({pfx, "_rvalid"}, rv, 1'b1);
        check_value({pfx, "_r"}, got, first);
      end else if (rv) begin
        seen  = 1'b1;
        first = got;
      end
      done = rv && rdy;
      if (!done) begin
        @(posedge clk);
        #1;
      end
    end
    check_done(done, {pfx, " read response handshake"});
    check_value({pfx, "_r.data"}, got.data, exp.data);
    check_value({pfx, "_r.resp"}, got.resp, exp.resp);
    @(posedge clk);
    #1;
    if (use_ls) begin
      ls_rready = 1'b0;
    end else begin
      if_rready = 1'b0;
    end
  endtask

  task automatic ls_read(input addr_t addr);
    read_port(1'b1, addr);
  endtask

  task automatic if_read(input addr_t addr);
    read_port(1'b0, addr);
  endtask

  task automatic parallel_read(input addr_t if_addr, input addr_t ls_addr);
    int if0;
    int ls0;
    if0 = if_resp_cnt;
    ls0 = ls_resp_cnt;
    fork
      if_read(if_addr);
      ls_read(ls_addr);
    join
    check_value("if response count", if_resp_cnt - if0, 1);
    check_value("ls response count", ls_resp_cnt - ls0, 1);
  endtask

  task automatic report(input string name, input int err0);
    $display("%-20s done, %0d errors", name, errors - err0);
  endtask

  task automatic full_word_test();
    int    e0;
    addr_t a;
    e0 = errors;
    repeat (8) begin
      a = rand_addr();
      used.push_back(a);
      ls_write(a, $urandom, 4'hF);
      ls_read(a);
    end
    report("full word", e0);
  endtask

  task automatic strobe_test();
    int    e0;
    addr_t a;
    e0 = errors;
    repeat (6) begin
      a = rand_addr();
      used.push_back(a);
      ls_write(a, $urandom, 4'hF);
      repeat (3) begin
        ls_write(a, $urandom, strb_t'($urandom));
      end
      ls_read(a);
    end
    report("byte strobes", e0);
  endtask

  task automatic shared_test();
    int e0;
    e0 = errors;
    foreach (used[i]) begin
      if_read(used[i]);
    end
    for (int i = 0; i + 1 < used.size(); i += 2) begin
      parallel_read(used[i], used[i + 1]);
    end
    report("shared memory", e0);
  endtask

  task automatic range_test();
    int e0;
    e0 = errors;
    ls_read(32'd4096);
    if_read(32'hFFFF_FFFC);
    parallel_read(32'd4096 + rand_addr(), 32'h8000_0000);
    // Aliases of written words if the upper bits were dropped.
    foreach (used[i]) begin
      ls_write(used[i] + 32'd4096, $urandom, 4'hF);
    end
    foreach (used[i]) begin
      ls_read(used[i]);
    end
    report("range errors", e0);
  endtask

  task automatic backpressure_test();
    int e0;
    e0 = errors;
    stall_en = 1'b1;
    foreach (used[i]) begin
      ls_write(used[i], $urandom, strb_t'($urandom));
      ls_read(used[i]);
    end
    for (int i = 0; i + 1 < used.size(); i += 2) begin
      parallel_read(used[i + 1], used[i]);
    end
    stall_en = 1'b0;
    report("back-pressure", e0);
  endtask

  initial begin
    void'($urandom(40321));
    clk = 1'b0;
    rst = 1'b1;
    if_ar = '0;
    if_arvalid = 1'b0;
    if_rready = 1'b0;
    ls_ar = '0;
    ls_arvalid = 1'b0;
    ls_rready = 1'b0;
    ls_aw = '0;
    ls_awvalid = 1'b0;
    ls_w = '0;
    ls_wvalid = 1'b0;
    ls_bready = 1'b0;
    checks = 0;
    errors = 0;
    if_resp_cnt = 0;
    ls_resp_cnt = 0;
    stall_en = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;

    full_word_test();
    strobe_test();
    shared_test();
    range_test();
    backpressure_test();

    errors += i_dut.i_sram.i_sva.fails;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/lfsr.sv
`timescale 1ns/10ps
`default_nettype none

module lfsr
  import mem_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  output lfsr_t dout
);

  // Polynomial x^8 + x^6 + x^5 + x^4 + 1, right-shifting Galois form.
  localparam lfsr_t TAPS = 8'hB8;

  lfsr_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= LFSR_SEED;
    end else if (state[0]) begin
      state <= (state >> 1) ^ TAPS;
    end else begin
      state <= state >> 1;
    end
  end

  assign dout = state;

endmodule

`default_nettype wire

// File: verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [9:0]  word_idx_t;
  typedef logic [7:0]  lfsr_t;

  // 1024 words, so byte addresses below 4096 are valid.
  localparam int unsigned MEM_WORDS = 1024;
  localparam int unsigned ADDR_LSB  = 2;
  localparam lfsr_t       LFSR_SEED = 8'hA5;

  localparam logic RESP_OK  = 1'b0;
  localparam logic RESP_ERR = 1'b1;

  typedef struct packed {
    addr_t addr;
  } ar_t;

  typedef struct packed {
    data_t data;
    logic  resp;
  } r_t;

  typedef struct packed {
    addr_t addr;
  } aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_t;

  typedef struct packed {
    logic resp;
  } b_t;

  typedef enum logic [1:0] {RD_IDLE, RD_WAIT, RD_RESP} rd_state_e;

  typedef enum logic [1:0] {WR_ADDR, WR_DATA, WR_WAIT, WR_RESP} wr_state_e;

endpackage

`default_nettype wire

// File: verilog/mem_subsys_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_top
  import mem_pkg::*;
(
  input  logic clk,
  input  logic rst,

  input  ar_t  if_ar,
  input  logic if_arvalid,
  output logic if_arready,
  output r_t   if_r,
  output logic if_rvalid,
  input  logic if_rready,

  input  ar_t  ls_ar,
  input  logic ls_arvalid,
  output logic ls_arready,
  output r_t   ls_r,
  output logic ls_rvalid,
  input  logic ls_rready,

  input  aw_t  ls_aw,
  input  logic ls_awvalid,
  output logic ls_awready,
  input  w_t   ls_w,
  input  logic ls_wvalid,
  output logic ls_wready,
  output b_t   ls_b,
  output logic ls_bvalid,
  input  logic ls_bready
);

  ar_t   s_ar;
  logic  s_arvalid;
  logic  s_arready;
  r_t    s_r;
  logic  s_rvalid;
  logic  s_rready;
  lfsr_t rnd;

  rd_arbiter i_arb (
    .clk        (clk),
    .rst        (rst),
    .if_ar      (if_ar),
    .if_arvalid (if_arvalid),
    .if_arready (if_arready),
    .if_r       (if_r),
    .if_rvalid  (if_rvalid),
    .if_rready  (if_rready),
    .ls_ar      (ls_ar),
    .ls_arvalid (ls_arvalid),
    .ls_arready (ls_arready),
    .ls_r       (ls_r),
    .ls_rvalid  (ls_rvalid),
    .ls_rready  (ls_rready),
    .s_ar       (s_ar),
    .s_arvalid  (s_arvalid),
    .s_arready  (s_arready),
    .s_r        (s_r),
    .s_rvalid   (s_rvalid),
    .s_rready   (s_rready)
  );

  // Write channels go straight from load/store to the slave.
  sram_slave i_sram (
    .clk     (clk),
    .rst     (rst),
    .ar      (s_ar),
    .arvalid (s_arvalid),
    .arready (s_arready),
    .r       (s_r),
    .rvalid  (s_rvalid),
    .rready  (s_rready),
    .aw      (ls_aw),
    .awvalid (ls_awvalid),
    .awready (ls_awready),
    .w       (ls_w),
    .wvalid  (ls_wvalid),
    .wready  (ls_wready),
    .b       (ls_b),
    .bvalid  (ls_bvalid),
    .bready  (ls_bready),
    .rnd     (rnd)
  );

  lfsr i_lfsr (
    .clk  (clk),
    .rst  (rst),
    .dout (rnd)
  );

endmodule

`default_nettype wire

// File: verilog/rd_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module rd_arbiter
  import mem_pkg::*;
(
  input  logic clk,
  input  logic rst,

  // Fetch master.
  input  ar_t  if_ar,
  input  logic if_arvalid,
  output logic if_arready,
  output r_t   if_r,
  output logic if_rvalid,
  input  logic if_rready,

  // Load/store master.
  input  ar_t  ls_ar,
  input  logic ls_arvalid,
  output logic ls_arready,
  output r_t   ls_r,
  output logic ls_rvalid,
  input  logic ls_rready,

  // Slave read channel.
  output ar_t  s_ar,
  output logic s_arvalid,
  input  logic s_arready,
  input  r_t   s_r,
  input  logic s_rvalid,
  output logic s_rready
);

  logic busy;
  logic grant_ls;
  logic last_ls;
  logic pick_ls;
  logic sel_ls;
  logic ar_fire;
  logic r_fire;

  // Round robin. The master not served last wins a tie.
  assign pick_ls = ls_arvalid && (!if_arvalid || !last_ls);

  // While idle the fresh pick drives the slave, so no cycle is lost.
  assign sel_ls = busy ? grant_ls : pick_ls;

  assign s_ar      = sel_ls ? ls_ar : if_ar;
  assign s_arvalid = !busy && (sel_ls ? ls_arvalid : if_arvalid);
  assign s_rready  = busy && (grant_ls ? ls_rready : if_rready);

  assign ar_fire = s_arvalid && s_arready;
  assign r_fire  = s_rvalid && s_rready;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      grant_ls <= 1'b0;
      // Fetch goes first after reset.
      last_ls  <= 1'b1;
    end else begin
      if (ar_fire) begin
        busy     <= 1'b1;
        grant_ls <= sel_ls;
        last_ls  <= sel_ls;
      end else if (r_fire) begin
        busy <= 1'b0;
      end
    end
  end

  assign if_arready = !busy && !sel_ls && s_arready;
  assign ls_arready = !busy && sel_ls && s_arready;

  // Response payload is shared; only the granted side sees rvalid.
  assign if_r      = s_r;
  assign ls_r      = s_r;
  assign if_rvalid = busy && !grant_ls && s_rvalid;
  assign ls_rvalid = busy && grant_ls && s_rvalid;

endmodule

`default_nettype wire

// File: verilog/sram_slave.sv
`timescale 1ns/10ps
`default_nettype none

module sram_slave
  import mem_pkg::*;
(
  input  logic  clk,
  input  logic  rst,

  // Read channel.
  input  ar_t   ar,
  input  logic  arvalid,
  output logic  arready,
  output r_t    r,
  output logic  rvalid,
  input  logic  rready,

  // Write channel.
  input  aw_t   aw,
  input  logic  awvalid,
  output logic  awready,
  input  w_t    w,
  input  logic  wvalid,
  output logic  wready,
  output b_t    b,
  output logic  bvalid,
  input  logic  bready,

  input  lfsr_t rnd
);

  data_t      mem [MEM_WORDS];

  rd_state_e  rd_state;
  wr_state_e  wr_state;
  logic [1:0] rd_cnt;
  logic [1:0] wr_cnt;

  word_idx_t  rd_idx;
  logic       rd_ok;
  word_idx_t  wr_idx;
  logic       wr_ok;
  data_t      wr_data;
  strb_t      wr_strb;

  logic       ar_fire;
  logic       r_fire;
  logic       aw_fire;
  logic       w_fire;
  logic       b_fire;
  logic       rd_done;
  logic       wr_done;

  function automatic logic in_range(addr_t a);
    return (a >> ADDR_LSB) < MEM_WORDS;
  endfunction

  function automatic word_idx_t word_idx(addr_t a);
    return a[ADDR_LSB +: $bits(word_idx_t)];
  endfunction

  assign ar_fire = arvalid && arready;
  assign r_fire  = rvalid && rready;
  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign b_fire  = bvalid && bready;

  // Last cycle of the random wait.
  assign rd_done = (rd_state == RD_WAIT) && (rd_cnt == 2'd0);
  assign wr_done = (wr_state == WR_WAIT) && (wr_cnt == 2'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= RD_IDLE;
      arready  <= 1'b1;
      rvalid   <= 1'b0;
      rd_cnt   <= 2'd0;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (ar_fire) begin
            arready  <= 1'b0;
            rd_cnt   <= rnd[1:0];
            rd_state <= RD_WAIT;
          end
        end
        RD_WAIT: begin
          if (rd_cnt == 2'd0) begin
            rvalid   <= 1'b1;
            rd_state <= RD_RESP;
          end else begin
            rd_cnt <= rd_cnt - 2'd1;
          end
        end
        RD_RESP: begin
          if (r_fire) begin
            rvalid   <= 1'b0;
            arready  <= 1'b1;
            rd_state <= RD_IDLE;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rd_idx <= word_idx(ar.addr);
      rd_ok  <= in_range(ar.addr);
    end
    if (rd_done) begin
      r.data <= rd_ok ? mem[rd_idx] : '0;
      r.resp <= rd_ok ? RESP_OK : RESP_ERR;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= WR_ADDR;
      awready  <= 1'b1;
      wready   <= 1'b0;
      bvalid   <= 1'b0;
      wr_cnt   <= 2'd0;
    end else begin
      case (wr_state)
        WR_ADDR: begin
          if (aw_fire) begin
            awready  <= 1'b0;
            wready   <= 1'b1;
            wr_state <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (w_fire) begin
            wready   <= 1'b0;
            wr_cnt   <= rnd[1:0];
            wr_state <= WR_WAIT;
          end
        end
        WR_WAIT: begin
          if (wr_cnt == 2'd0) begin
            bvalid   <= 1'b1;
            wr_state <= WR_RESP;
          end else begin
            wr_cnt <= wr_cnt - 2'd1;
          end
        end
        WR_RESP: begin
          if (b_fire) begin
            bvalid   <= 1'b0;
            awready  <= 1'b1;
            wr_state <= WR_ADDR;
          end
        end
        default: wr_state <= WR_ADDR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      wr_idx <= word_idx(aw.addr);
      wr_ok  <= in_range(aw.addr);
    end
    if (w_fire) begin
      wr_data <= w.data;
      wr_strb <= w.strb;
    end
    if (wr_done) begin
      b.resp <= wr_ok ? RESP_OK : RESP_ERR;
    end
  end

  // Byte-masked write, only for addresses inside the array.
  always_ff @(posedge clk) begin
    if (wr_done && wr_ok) begin
      for (int i = 0; i < $bits(strb_t); i++) begin
        if (wr_strb[i]) begin
          mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire
